// File: project.f
+incdir+.
fp_add_pkg.sv
fp_operand_unpack.sv
fp_align_shift.sv
fp_pipe_stage.sv
fp_mag_adder.sv
fp_result_pack.sv
fp_add_top.sv
tb_clock_gen.sv
fp_add_sva.sv
fp_add_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fp_add_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: fp_add_tb.sv
/* random-stimulus testbench for the add/sub front end, with a reference model */

`default_nettype none

`include "fp_add_params.svh"

module fp_add_tb;

  logic clk, rst, sub, new_request, ack, ready, done;
  logic wb_carry, wb_hidden, wb_invalid, wb_special;
  fp_add_pkg::flt_t a, b, wb_rd;
  fp_add_pkg::rm_t  rm;
  fp_add_pkg::id_t  issue_id, wb_id;
  fp_add_pkg::grs_t wb_grs;
  logic [4:0]       wb_clz;
  // expected writeback fields rd, carry, hidden, grs, clz, invalid and special
  logic [43:0] exp_q[$];
  logic [2:0]  id_q[$];
  int          cyc_q[$];
  int          cycle = 0;
  int          accepted = 0;
  int          checked = 0;

  tb_clock_gen clk_gen0 (.clk(clk), .rst(rst));

  fp_add_top dut0 (
    .clk(clk), .rst(rst), .a(a), .b(b), .sub(sub), .rm(rm),
    .new_request(new_request), .issue_id(issue_id), .ack(ack),
    .ready(ready), .done(done), .wb_id(wb_id), .wb_rd(wb_rd),
    .wb_carry(wb_carry), .wb_hidden(wb_hidden), .wb_grs(wb_grs),
    .wb_clz(wb_clz), .wb_invalid(wb_invalid), .wb_special(wb_special)
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string field, input int op,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected == actual) else begin
      stop_with_failure($sformatf("FAILED %s op %0d: expected %h actual %h",
                                  field, op, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // reference model in integer arithmetic
  function automatic logic [43:0] model_result(input logic [31:0] x, input logic [31:0] y,
                                               input logic op_sub, input logic [2:0] mode);
    logic        sx, sy, xi, yi, xn, yn, inv, nan, inf, bsign, borrow, zero, sign;
    int          ex, ey, big_e, diff, clz;
    longint      mx, my, big_m, small_x, r;
    logic [24:0] mag;
    logic [31:0] rd;
    sx = x[31];
    sy = y[31] ^ op_sub;
    xi = (x[30:23] == 8'hff) && (x[22:0] == 23'd0);
    yi = (y[30:23] == 8'hff) && (y[22:0] == 23'd0);
    xn = (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    yn = (y[30:23] == 8'hff) && (y[22:0] != 23'd0);
    inv = (xn && !x[22]) || (yn && !y[22]) || (xi && yi && (sx != sy));
    nan = xn || yn || inv;
    inf = (xi || yi) && !nan;
    mx = longint'({x[30:23] != 8'd0, x[22:0]});
    my = longint'({y[30:23] != 8'd0, y[22:0]});
    ex = (x[30:23] == 8'd0) ? 1 : int'(x[30:23]);
    ey = (y[30:23] == 8'd0) ? 1 : int'(y[30:23]);
    if (ey > ex) begin
      big_e = ey;
      big_m = my;
      bsign = sy;
      small_x = mx << 3;
      diff = ey - ex;
    end else begin
      big_e = ex;
      big_m = mx;
      bsign = sx;
      small_x = my << 3;
      diff = ex - ey;
    end
    // shifted-out bits fold into the sticky position
    if (diff >= 27) begin
      small_x = longint'(small_x != 0);
    end else begin
      small_x = (small_x >> diff) | longint'((small_x & ((longint'(1) << diff) - 1)) != 0);
    end
    r = (sx != sy) ? (big_m << 3) - small_x : (big_m << 3) + small_x;
    borrow = r < 0;
    if (borrow) r = -r;
    mag = 25'(r >> 3);
    zero = (diff == 0) && (r == 0);
    sign = zero ? ((sx != sy) ? (mode == `FP_RM_RDN) : bsign) : (bsign ^ borrow);
    clz = 0;
    while (clz < 24 && !mag[23 - clz]) clz++;
    if (mag[24] || nan || inf) clz = 0;
    rd = {sign, zero ? 8'd0 : 8'(big_e), mag[22:0]};
    if (nan) return {32'h7fc00000, 10'd0, inv, 1'b1};
    if (inf) return {(xi ? sx : sy), 8'hff, 23'd0, 10'd0, 1'b0, 1'b1};
    return {rd, mag[24], mag[23], 3'(r), 5'(clz), 1'b0, 1'b0};
  endfunction

  // operand mix of random, same or near exponent, zero, subnormal, inf, nans and cancel
  function automatic logic [31:0] pick_operand(input logic [31:0] other);
    logic [31:0] r;
    r = $urandom;
    case ($urandom % 10)
      0: r[30:23] = other[30:23];
      1: r[30:23] = other[30:23] - 8'($urandom % 4);
      2: r[30:0] = 31'd0;
      3: r[30:23] = 8'd0;
      4: r[30:0] = {8'hff, 23'd0};
      5: r[30:22] = 9'h1ff;
      6: begin
        r[30:22] = 9'h1fe;
        r[0] = 1'b1;
      end
      7: r = other ^ {1'($urandom), 31'd0};
      default: ;
    endcase
    return r;
  endfunction

  ////////////////////////////////////////
  // monitor sampled on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (done) begin
        assert (exp_q.size() != 0) else begin
          stop_with_failure("done raised with no accepted operation outstanding");
        end
        // done never shows before the second edge after acceptance
        assert (cycle - cyc_q[0] >= 2) else begin
          stop_with_failure($sformatf("FAILED latency op %0d: expected at least 2 actual %0d",
                                      checked, cycle - cyc_q[0]));
        end
      end
      if (done && ack) begin
        check_value("wb_id", checked, 32'(id_q.pop_front()), 32'(wb_id));
        void'(cyc_q.pop_front());
        check_value("wb_rd", checked, exp_q[0][43:12], wb_rd);
        check_value("wb_carry", checked, 32'(exp_q[0][11]), 32'(wb_carry));
        check_value("wb_hidden", checked, 32'(exp_q[0][10]), 32'(wb_hidden));
        check_value("wb_grs", checked, 32'(exp_q[0][9:7]), 32'(wb_grs));
        check_value("wb_clz", checked, 32'(exp_q[0][6:2]), 32'(wb_clz));
        check_value("wb_invalid", checked, 32'(exp_q[0][1]), 32'(wb_invalid));
        check_value("wb_special", checked, 32'(exp_q[0][0]), 32'(wb_special));
        void'(exp_q.pop_front());
        checked++;
      end
      if (new_request && ready) begin
        exp_q.push_back(model_result(a, b, sub, rm));
        id_q.push_back(issue_id);
        cyc_q.push_back(cycle);
        accepted++;
      end
    end
    cycle++;
  end

  initial begin
    int t;
    void'($urandom(71));
    a = '0; b = '0; sub = 1'b0; rm = '0;
    new_request = 1'b0; issue_id = '0; ack = 1'b0;
    t = 0;
    while (rst !== 1'b0 && t < 20) begin
      @(posedge clk);
      t++;
    end
    if (rst !== 1'b0) stop_with_failure("reset was never released");
    for (int n = 0; n < 800; n++) begin
      @(posedge clk);
      #10;
      a = pick_operand($urandom);
      b = pick_operand(a);
      sub = 1'($urandom);
      rm = 3'($urandom % 5);
      issue_id = 3'(accepted);
      new_request = ($urandom % 10) < 7;
      ack = ($urandom % 10) < 7;
    end
    @(posedge clk);
    #10;
    new_request = 1'b0;
    ack = 1'b1;
    // drain what is still in flight
    t = 0;
    while (exp_q.size() != 0 && t < 50) begin
      @(posedge clk);
      t++;
    end
    if (exp_q.size() == 0 && checked == accepted) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("timeout waiting for the pipeline to drain");
    end
  end

endmodule

`default_nettype wire

// File: fp_add_sva.sv
/* handshake and writeback assertions, bound to the add/sub top level */

`default_nettype none

module fp_add_sva (
  input wire logic             clk,
  input wire logic             rst,
  input wire logic             ready,
  input wire logic             done,
  input wire logic             ack,
  input wire fp_add_pkg::flt_t wb_rd,
  input wire logic             wb_invalid,
  input wire logic             wb_special
);

  // both stages empty once reset drops
  ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> ready)
    else $error("ready low in the first cycle after reset");

  // writeback holds until acknowledged
  done_held: assert property (@(posedge clk) disable iff (rst)
    done && !ack |=> done && $stable(wb_rd))
    else $error("done or wb_rd changed while waiting for ack");

  invalid_is_special: assert property (@(posedge clk) disable iff (rst)
    wb_invalid |-> wb_special)
    else $error("wb_invalid set without wb_special");

endmodule

bind fp_add_top fp_add_sva sva0 (
  .clk(clk), .rst(rst), .ready(ready), .done(done), .ack(ack),
  .wb_rd(wb_rd), .wb_invalid(wb_invalid), .wb_special(wb_special)
);

`default_nettype wire

// File: tb_clock_gen.sv
/* testbench clock and reset generator */

`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held for four rising edges
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: fp_add_top.sv
/* two-stage pipelined binary32 add/sub front end */

`default_nettype none

`include "fp_add_params.svh"

module fp_add_top (
  input  logic             clk,
  input  logic             rst,
  input  fp_add_pkg::flt_t a,
  input  fp_add_pkg::flt_t b,
  input  logic             sub,
  input  fp_add_pkg::rm_t  rm,
  input  logic             new_request,
  input  fp_add_pkg::id_t  issue_id,
  input  logic             ack,
  output logic             ready,
  output logic             done,
  output fp_add_pkg::id_t  wb_id,
  output fp_add_pkg::flt_t wb_rd,
  output logic             wb_carry,
  output logic             wb_hidden,
  output fp_add_pkg::grs_t wb_grs,
  output logic [4:0]       wb_clz,
  output logic             wb_invalid,
  output logic             wb_special
);

  logic                       big_sign, subtract, zero_sign, same_expo;
  logic                       invalid, is_nan, is_inf, inf_sign;
  fp_add_pkg::expo_t          big_expo, expo_diff;
  fp_add_pkg::mant_t          big_mant, small_mant, small_aligned;
  fp_add_pkg::grs_t           small_grs, sum_grs;
  logic [`FP_FRAC_WIDTH+1:0]  sum_mag;
  logic                       borrow, a_valid, b_advance;
  fp_add_pkg::id_t            a_id;
  fp_add_pkg::align_payload_t a_in, a_out;
  fp_add_pkg::sum_payload_t   b_in, b_out;

  ////////////////////////////////////////
  // unpack and align

  fp_operand_unpack u_unpack (
    .a(a), .b(b), .sub(sub), .rm(rm),
    .big_sign(big_sign), .big_expo(big_expo), .big_mant(big_mant),
    .small_mant(small_mant), .expo_diff(expo_diff), .subtract(subtract),
    .zero_sign(zero_sign), .same_expo(same_expo), .invalid(invalid),
    .is_nan(is_nan), .is_inf(is_inf), .inf_sign(inf_sign)
  );

  fp_align_shift u_align (
    .mant(small_mant), .shift(expo_diff), .aligned(small_aligned), .grs(small_grs)
  );

  assign a_in = '{big_sign: big_sign, big_expo: big_expo, big_mant: big_mant,
                  small_mant: small_aligned, small_grs: small_grs,
                  subtract: subtract, zero_sign: zero_sign, same_expo: same_expo,
                  invalid: invalid, is_nan: is_nan, is_inf: is_inf,
                  inf_sign: inf_sign};

  fp_pipe_stage #(.payload_t(fp_add_pkg::align_payload_t)) stage_a (
    .clk(clk), .rst(rst), .in_valid(new_request), .in_id(issue_id), .in_data(a_in),
    .next_advance(b_advance), .advance(ready), .valid(a_valid), .id(a_id), .data(a_out)
  );

  ////////////////////////////////////////
  // add and writeback

  fp_mag_adder u_adder (
    .big_mant(a_out.big_mant), .small_mant(a_out.small_mant),
    .small_grs(a_out.small_grs), .subtract(a_out.subtract),
    .mag(sum_mag), .mag_grs(sum_grs), .borrow(borrow)
  );

  // sign of the larger operand, flipped when the subtraction borrowed
  assign b_in = '{mag: sum_mag, grs: sum_grs, big_expo: a_out.big_expo,
                  sign: a_out.big_sign ^ borrow, subtract: a_out.subtract,
                  zero_sign: a_out.zero_sign, same_expo: a_out.same_expo,
                  invalid: a_out.invalid, is_nan: a_out.is_nan,
                  is_inf: a_out.is_inf, inf_sign: a_out.inf_sign};

  fp_pipe_stage #(.payload_t(fp_add_pkg::sum_payload_t)) stage_b (
    .clk(clk), .rst(rst), .in_valid(a_valid), .in_id(a_id), .in_data(b_in),
    .next_advance(ack | ~done), .advance(b_advance), .valid(done), .id(wb_id),
    .data(b_out)
  );

  fp_result_pack u_pack (
    .sum(b_out), .rd(wb_rd), .carry(wb_carry), .hidden(wb_hidden), .grs(wb_grs),
    .clz(wb_clz), .invalid(wb_invalid), .special(wb_special)
  );

endmodule

`default_nettype wire

// File: fp_result_pack.sv
/* zero detect, result sign, leading zero count and special results */

`default_nettype none

`include "fp_add_params.svh"

module fp_result_pack (
  input  fp_add_pkg::sum_payload_t sum,
  output fp_add_pkg::flt_t         rd,
  output logic                     carry,
  output logic                     hidden,
  output fp_add_pkg::grs_t         grs,
  output logic [4:0]               clz,
  output logic                     invalid,
  output logic                     special
);

  localparam int FW = `FP_FRAC_WIDTH;

  logic              is_zero;
  logic              res_sign;
  fp_add_pkg::expo_t res_expo;
  logic [4:0]        lz;

  ////////////////////////////////////////
  // zero result and sign

  // a non-zero exact result can only cancel when exponents matched
  assign is_zero = sum.same_expo & ~|sum.mag & ~|sum.grs;

  // exact zero from a subtraction takes its sign from the rounding mode
  assign res_sign = (is_zero & sum.subtract) ? sum.zero_sign : sum.sign;
  assign res_expo = is_zero ? '0 : sum.big_expo;

  assign special = sum.is_nan | sum.is_inf;
  assign invalid = sum.invalid;

  ////////////////////////////////////////
  // leading zeros of hidden plus fraction

  always_comb begin
    lz = 5'(FW + 1);
    // upward scan, the highest set bit wins
    for (int i = 0; i <= FW; i++) begin
      if (sum.mag[i]) begin
        lz = 5'(FW - i);
      end
    end
  end

  assign clz = (sum.mag[FW+1] | special) ? 5'd0 : lz;

  ////////////////////////////////////////
  // writeback fields
  assign carry  = special ? 1'b0 : sum.mag[FW+1];
  assign hidden = special ? 1'b0 : sum.mag[FW];
  assign grs    = special ? '0 : sum.grs;

  always_comb begin
    if (sum.is_nan) begin
      rd = `FP_CANONICAL_NAN;
    end else if (sum.is_inf) begin
      rd = {sum.inf_sign, {`FP_EXPO_WIDTH{1'b1}}, {FW{1'b0}}};
    end else begin
      rd = {res_sign, res_expo, sum.mag[FW-1:0]};
    end
  end

endmodule

`default_nettype wire

// File: fp_mag_adder.sv
/* magnitude add or subtract with borrow correction */

`default_nettype none

`include "fp_add_params.svh"

module fp_mag_adder (
  input  fp_add_pkg::mant_t          big_mant,
  input  fp_add_pkg::mant_t          small_mant,
  input  fp_add_pkg::grs_t           small_grs,
  input  logic                       subtract,
  output logic [`FP_FRAC_WIDTH+1:0]  mag,
  output fp_add_pkg::grs_t           mag_grs,
  output logic                       borrow
);

  // extended operand width of significand plus grs
  localparam int XW = `FP_FRAC_WIDTH + 1 + `FP_GRS_WIDTH;

  logic [XW:0]   in_big;
  logic [XW:0]   in_small;
  logic [XW+1:0] raw;
  logic [XW:0]   fixed;

  // one bit of headroom for the carry of an addition
  assign in_big   = {1'b0, big_mant, {`FP_GRS_WIDTH{1'b0}}};
  assign in_small = {1'b0, small_mant, small_grs} ^ {(XW+1){subtract}};

  // ones complement plus carry-in gives big - small
  assign raw = {1'b0, in_big} + {1'b0, in_small} + {{(XW+1){1'b0}}, subtract};

  // no carry out on a subtract means small was the larger one
  assign borrow = subtract & ~raw[XW+1];

  // negate back to the true magnitude
  assign fixed = borrow ? (~raw[XW:0] + {{XW{1'b0}}, 1'b1}) : raw[XW:0];

  assign mag     = fixed[XW:`FP_GRS_WIDTH];
  assign mag_grs = fixed[`FP_GRS_WIDTH-1:0];

endmodule

`default_nettype wire

// File: fp_pipe_stage.sv
/* one pipeline register stage with valid, tag and typed payload */

`default_nettype none

module fp_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  fp_add_pkg::id_t in_id,
  input  payload_t        in_data,
  input  logic            next_advance,
  output logic            advance,
  output logic            valid,
  output fp_add_pkg::id_t id,
  output payload_t        data
);

  // move when empty or when the next stage takes our contents
  assign advance = ~valid | next_advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (advance) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id   <= in_id;
      data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: fp_align_shift.sv
/* right-shift alignment of the smaller significand with guard, round and sticky */

`default_nettype none

`include "fp_add_params.svh"

module fp_align_shift (
  input  fp_add_pkg::mant_t mant,
  input  fp_add_pkg::expo_t shift,
  output fp_add_pkg::mant_t aligned,
  output fp_add_pkg::grs_t  grs
);

  // significand width and its width with grs positions appended
  localparam int MW = `FP_FRAC_WIDTH + 1;
  localparam int XW = MW + `FP_GRS_WIDTH;

  // upper half keeps the aligned value, lower half catches shifted-out bits
  logic [2*XW-1:0] window;
  logic            far;

  assign window = {mant, {`FP_GRS_WIDTH{1'b0}}, {XW{1'b0}}} >> shift;

  // everything shifted past the sticky position
  assign far = shift >= fp_add_pkg::expo_t'(XW);

  always_comb begin
    aligned = '0;
    grs     = '0;
    if (far) begin
      grs[0] = |mant;
    end else begin
      aligned = window[2*XW-1 -: MW];
      grs[2]  = window[XW+2];
      grs[1]  = window[XW+1];
      // sticky collects its own position and all lower bits
      grs[0]  = window[XW] | (|window[XW-1:0]);
    end
  end

endmodule

`default_nettype wire

// File: fp_operand_unpack.sv
/* operand unpacking, classification, swap and exponent difference */

`default_nettype none

`include "fp_add_params.svh"

module fp_operand_unpack (
  input  fp_add_pkg::flt_t  a,
  input  fp_add_pkg::flt_t  b,
  input  logic              sub,
  input  fp_add_pkg::rm_t   rm,
  output logic              big_sign,
  output fp_add_pkg::expo_t big_expo,
  output fp_add_pkg::mant_t big_mant,
  output fp_add_pkg::mant_t small_mant,
  output fp_add_pkg::expo_t expo_diff,
  output logic              subtract,
  output logic              zero_sign,
  output logic              same_expo,
  output logic              invalid,
  output logic              is_nan,
  output logic              is_inf,
  output logic              inf_sign
);

  localparam int EW = `FP_EXPO_WIDTH;
  localparam int FW = `FP_FRAC_WIDTH;

  logic              a_sign, b_sign;
  fp_add_pkg::expo_t a_expo, b_expo;
  fp_add_pkg::expo_t a_eff, b_eff;
  logic [FW-1:0]     a_frac, b_frac;
  fp_add_pkg::mant_t a_mant, b_mant;
  logic              a_inf, b_inf, a_nan, b_nan, a_snan, b_snan;
  logic              swap;

  // b's sign is flipped for a subtraction
  assign a_sign = a[EW+FW];
  assign b_sign = b[EW+FW] ^ sub;
  assign a_expo = a[FW+:EW];
  assign b_expo = b[FW+:EW];
  assign a_frac = a[FW-1:0];
  assign b_frac = b[FW-1:0];

  assign a_mant = {|a_expo, a_frac};
  assign b_mant = {|b_expo, b_frac};
  // subnormals sit at exponent 1 without the hidden bit
  assign a_eff = (a_expo == '0) ? fp_add_pkg::expo_t'(1) : a_expo;
  assign b_eff = (b_expo == '0) ? fp_add_pkg::expo_t'(1) : b_expo;

  ////////////////////////////////////////
  // classification
  assign a_inf  = (&a_expo) & ~|a_frac;
  assign b_inf  = (&b_expo) & ~|b_frac;
  assign a_nan  = (&a_expo) & |a_frac;
  assign b_nan  = (&b_expo) & |b_frac;
  assign a_snan = a_nan & ~a_frac[FW-1];
  assign b_snan = b_nan & ~b_frac[FW-1];

  assign invalid  = a_snan | b_snan | (a_inf & b_inf & (a_sign ^ b_sign));
  assign is_nan   = a_nan | b_nan | invalid;
  assign is_inf   = (a_inf | b_inf) & ~is_nan;
  assign inf_sign = a_inf ? a_sign : b_sign;

  ////////////////////////////////////////
  // swap, ties keep a in front
  assign swap = b_eff > a_eff;

  always_comb begin
    if (swap) begin
      big_sign   = b_sign;
      big_expo   = b_eff;
      big_mant   = b_mant;
      small_mant = a_mant;
      expo_diff  = b_eff - a_eff;
    end else begin
      big_sign   = a_sign;
      big_expo   = a_eff;
      big_mant   = a_mant;
      small_mant = b_mant;
      expo_diff  = a_eff - b_eff;
    end
  end

  assign subtract  = a_sign ^ b_sign;
  assign zero_sign = (rm == `FP_RM_RDN);
  assign same_expo = (expo_diff == '0);

endmodule

`default_nettype wire

// File: fp_add_pkg.sv
/* shared field types and the stage A / stage B payload structs */

`default_nettype none

`include "fp_add_params.svh"

package fp_add_pkg;

  typedef logic [`FP_EXPO_WIDTH+`FP_FRAC_WIDTH:0] flt_t;
  typedef logic [`FP_EXPO_WIDTH-1:0] expo_t;
  // hidden bit plus fraction
  typedef logic [`FP_FRAC_WIDTH:0] mant_t;
  typedef logic [`FP_GRS_WIDTH-1:0] grs_t;
  typedef logic [`FP_ID_WIDTH-1:0] id_t;
  typedef logic [`FP_RM_WIDTH-1:0] rm_t;

  // after swap and alignment
  typedef struct packed {
    logic  big_sign;
    expo_t big_expo;
    mant_t big_mant;
    mant_t small_mant;
    grs_t  small_grs;
    logic  subtract;
    logic  zero_sign;
    logic  same_expo;
    logic  invalid;
    logic  is_nan;
    logic  is_inf;
    logic  inf_sign;
  } align_payload_t;

  // after the magnitude adder, mag holds carry, hidden and fraction
  typedef struct packed {
    logic [`FP_FRAC_WIDTH+1:0] mag;
    grs_t  grs;
    expo_t big_expo;
    logic  sign;
    logic  subtract;
    logic  zero_sign;
    logic  same_expo;
    logic  invalid;
    logic  is_nan;
    logic  is_inf;
    logic  inf_sign;
  } sum_payload_t;

endpackage

`default_nettype wire

// File: fp_add_params.svh
/* width and constant macros for the binary32 add/sub front end */

`ifndef FP_ADD_PARAMS_SVH
`define FP_ADD_PARAMS_SVH

////////////////////////////////////////
// field widths

// binary32 exponent and stored fraction
`define FP_EXPO_WIDTH 8
`define FP_FRAC_WIDTH 23

// guard, round, sticky
`define FP_GRS_WIDTH 3

// tag and rounding mode
`define FP_ID_WIDTH 3
`define FP_RM_WIDTH 3

////////////////////////////////////////
// constants

// round toward negative infinity
`define FP_RM_RDN 3'd2

// quiet nan, exponent all ones and top fraction bit set
`define FP_CANONICAL_NAN {1'b0, {`FP_EXPO_WIDTH{1'b1}}, 1'b1, {(`FP_FRAC_WIDTH-1){1'b0}}}

`endif
